//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int XLEN       = 32;    // Instruction width
    localparam int OPC_W      = 7;     // Major opcode field
    localparam int CLS_W      = 4;
    localparam int STATE_W    = 4;
    localparam int PC_SEL_W   = 2;
    localparam int ADDR_SEL_W = 1;
    localparam int A_SEL_W    = 2;
    localparam int B_SEL_W    = 2;
    localparam int IMM_SEL_W  = 3;
    localparam int WD_SEL_W   = 2;

    // ------------------------------------------------------------
    // RV32I major opcodes, low "11" bits included
    // ------------------------------------------------------------
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;  // R-type ALU
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;  // I-type ALU
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;

    // Instruction class seen by sequencer and matrix
    typedef enum logic [CLS_W-1:0] {
        CLS_ALU_REG, CLS_ALU_IMM, CLS_LOAD, CLS_STORE, CLS_BRANCH,
        CLS_JAL, CLS_JALR, CLS_LUI, CLS_AUIPC, CLS_ILLEGAL
    } instr_class_e;

    // Sequencer steps
    typedef enum logic [STATE_W-1:0] {
        ST_VECTOR1, ST_VECTOR2, ST_FETCH, ST_DECODE, ST_EXECUTE,
        ST_MEM_READ, ST_MEM_WRITE, ST_WRITE_BACK, ST_BUG_HALT
    } ctrl_state_e;

    // ------------------------------------------------------------
    // Datapath select encodings
    // ------------------------------------------------------------
    typedef enum logic [PC_SEL_W-1:0] {
        PC_ALU_OUT      = 2'b00,   // Registered ALU result
        PC_ALU_DIRECT   = 2'b01,   // Live ALU output
        PC_RESET_VECTOR = 2'b10    // Reset vector constant
    } pc_sel_e;

    typedef enum logic [ADDR_SEL_W-1:0] {
        ADDR_PC      = 1'b0,
        ADDR_ALU_OUT = 1'b1
    } addr_sel_e;

    typedef enum logic [A_SEL_W-1:0] {
        A_RS1  = 2'b00,
        A_PC   = 2'b01,
        A_ZERO = 2'b10
    } a_sel_e;

    typedef enum logic [B_SEL_W-1:0] {
        B_RS2  = 2'b00,
        B_IMM  = 2'b01,
        B_FOUR = 2'b10
    } b_sel_e;

    typedef enum logic [IMM_SEL_W-1:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef enum logic [WD_SEL_W-1:0] {
        WD_ALU_OUT  = 2'b00,
        WD_MEM      = 2'b01,
        WD_JAL_LINK = 2'b10,       // Return address from JAL register
        WD_IMM      = 2'b11        // LUI immediate
    } wd_sel_e;

endpackage

//--- rtl/instr_classifier.sv
`timescale 1ns/100ps

module instr_classifier (
    input  logic [ctrl_pkg::XLEN-1:0] ir_i,       // IR contents
    output ctrl_pkg::instr_class_e    cls_o,      // Instruction class
    output ctrl_pkg::imm_sel_e        imm_sel_o   // Immediate format
);

    import ctrl_pkg::*;

    // ------------------------------------------------------------
    // Opcode field
    // ------------------------------------------------------------
    logic [OPC_W-1:0] opcode;

    // Full seven bits are compared, so a bad low pair is illegal too
    assign opcode = ir_i[OPC_W-1:0];

    // ------------------------------------------------------------
    // Class and immediate format lookup
    // ------------------------------------------------------------
    always_comb begin
        // Unmatched opcode
        cls_o     = CLS_ILLEGAL;
        imm_sel_o = IMM_I;

        case (opcode)
            OPC_OP: begin
                cls_o     = CLS_ALU_REG;
                imm_sel_o = IMM_I;      // No immediate, format unused
            end
            OPC_OP_IMM: begin
                cls_o     = CLS_ALU_IMM;
                imm_sel_o = IMM_I;
            end
            OPC_LOAD: begin
                cls_o     = CLS_LOAD;
                imm_sel_o = IMM_I;      // Address offset
            end
            OPC_STORE: begin
                cls_o     = CLS_STORE;
                imm_sel_o = IMM_S;      // Split offset
            end
            OPC_BRANCH: begin
                cls_o     = CLS_BRANCH;
                imm_sel_o = IMM_B;
            end
            OPC_JAL: begin
                cls_o     = CLS_JAL;
                imm_sel_o = IMM_J;
            end
            OPC_JALR: begin
                cls_o     = CLS_JALR;
                imm_sel_o = IMM_I;      // rs1 relative target
            end
            OPC_LUI: begin
                cls_o     = CLS_LUI;
                imm_sel_o = IMM_U;
            end
            OPC_AUIPC: begin
                cls_o     = CLS_AUIPC;
                imm_sel_o = IMM_U;      // PC relative upper
            end
            default: begin
                cls_o     = CLS_ILLEGAL;
                imm_sel_o = IMM_I;
            end
        endcase
    end

endmodule

//--- rtl/step_sequencer.sv
`timescale 1ns/100ps

module step_sequencer (
    input  logic                   clk_i,
    input  logic                   resetComplete,   // Sync reset, active high
    input  logic                   mem_busy_i,      // Memory not ready
    input  ctrl_pkg::instr_class_e cls_i,           // Class of the IR word
    output ctrl_pkg::ctrl_state_e  state_o          // Current step
);

    import ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;

    // ------------------------------------------------------------
    // Step register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            state <= ST_VECTOR1;    // Held here for the whole reset
        end else begin
            state <= next_state;
        end
    end

    assign state_o = state;

    // ------------------------------------------------------------
    // Next-step logic
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;

        case (state)
            // Two-step reset vector sequence
            ST_VECTOR1:
                next_state = ST_VECTOR2;        // PC loaded with vector
            ST_VECTOR2:
                next_state = ST_FETCH;

            ST_FETCH: begin
                if (mem_busy_i) begin
                    next_state = ST_FETCH;      // Wait for the word
                end else begin
                    next_state = ST_DECODE;     // IR loads this cycle
                end
            end

            ST_DECODE: begin
                // IR valid now, class is stable
                if (cls_i == CLS_ILLEGAL) begin
                    next_state = ST_BUG_HALT;
                end else begin
                    next_state = ST_EXECUTE;
                end
            end

            ST_EXECUTE: begin
                case (cls_i)
                    CLS_LOAD:   next_state = ST_MEM_READ;
                    CLS_STORE:  next_state = ST_MEM_WRITE;
                    CLS_BRANCH: next_state = ST_FETCH;     // PC already updated
                    CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_AUIPC,
                    CLS_JAL, CLS_JALR:
                        next_state = ST_WRITE_BACK;
                    default:    next_state = ST_BUG_HALT;  // Not reachable past decode
                endcase
            end

            // Memory steps stretch under back-pressure
            ST_MEM_READ: begin
                if (!mem_busy_i) begin
                    next_state = ST_WRITE_BACK;
                end
            end

            ST_MEM_WRITE: begin
                if (!mem_busy_i) begin
                    next_state = ST_FETCH;
                end
            end

            ST_WRITE_BACK:
                next_state = ST_FETCH;

            // Sticky, only reset leaves
            ST_BUG_HALT:
                next_state = ST_BUG_HALT;

            default:
                next_state = ST_VECTOR1;        // Undefined encoding recovers
        endcase
    end

endmodule

//--- rtl/control_matrix.sv
`timescale 1ns/100ps

module control_matrix (
    input  ctrl_pkg::ctrl_state_e  state_i,
    input  ctrl_pkg::instr_class_e cls_i,
    input  ctrl_pkg::imm_sel_e     imm_sel_i,
    input  logic                   mem_busy_i,
    input  logic                   branch_taken_i,  // Sampled in execute
    output logic                   ir_ld_o,         // IR load, active low
    output logic                   pc_ld_o,         // PC load, active low
    output logic                   mem_wr_o,        // Memory write, active low
    output logic                   mem_rd_o,        // Memory read, active low
    output logic                   rg_wr_o,         // Register file write, active low
    output logic                   alu_ld_o,        // ALU out register load, active low
    output logic                   jal_ld_o,        // Link register load, active low
    output logic                   ready_o,
    output logic                   halt_o,
    output ctrl_pkg::pc_sel_e      pc_src_o,
    output ctrl_pkg::addr_sel_e    addr_src_o,
    output ctrl_pkg::a_sel_e       a_src_o,
    output ctrl_pkg::b_sel_e       b_src_o,
    output ctrl_pkg::imm_sel_e     imm_src_o,
    output ctrl_pkg::wd_sel_e      wd_src_o
);

    import ctrl_pkg::*;

    always_comb begin
        // ------------------------------------------------------------
        // Inactive defaults
        // ------------------------------------------------------------
        ir_ld_o    = 1'b1;
        pc_ld_o    = 1'b1;
        mem_wr_o   = 1'b1;
        mem_rd_o   = 1'b0;          // Read enabled unless told otherwise
        rg_wr_o    = 1'b1;
        alu_ld_o   = 1'b1;
        jal_ld_o   = 1'b1;
        ready_o    = 1'b1;
        halt_o     = 1'b0;
        pc_src_o   = PC_ALU_OUT;
        addr_src_o = ADDR_PC;
        a_src_o    = A_RS1;
        b_src_o    = B_RS2;
        imm_src_o  = IMM_I;
        wd_src_o   = WD_ALU_OUT;

        case (state_i)
            ST_VECTOR1: begin
                pc_ld_o  = 1'b0;            // Load reset vector into PC
                pc_src_o = PC_RESET_VECTOR;
                ready_o  = 1'b0;
            end
            ST_VECTOR2: ;                   // Vector in PC, ready rises
            ST_FETCH: begin
                if (!mem_busy_i) begin
                    ir_ld_o = 1'b0;         // Word on the bus
                end
            end
            ST_DECODE: ;
            ST_EXECUTE: begin
                alu_ld_o = 1'b0;
                b_src_o  = B_IMM;           // All but ALU_REG use the immediate
                case (cls_i)
                    CLS_ALU_REG: b_src_o = B_RS2;
                    CLS_JALR:    jal_ld_o = 1'b0;     // Keep link value
                    CLS_JAL: begin
                        a_src_o  = A_PC;
                        jal_ld_o = 1'b0;
                    end
                    CLS_AUIPC:   a_src_o = A_PC;
                    CLS_LUI:     a_src_o = A_ZERO;
                    CLS_BRANCH: begin
                        a_src_o  = A_PC;              // Target is PC + imm
                        pc_ld_o  = !branch_taken_i;
                        pc_src_o = PC_ALU_DIRECT;
                    end
                    default: ;                        // RS1 + IMM
                endcase
            end
            ST_MEM_READ:
                addr_src_o = ADDR_ALU_OUT;            // Effective address
            ST_MEM_WRITE: begin
                addr_src_o = ADDR_ALU_OUT;
                mem_wr_o   = 1'b0;                    // Held until not busy
                mem_rd_o   = 1'b1;
            end
            ST_WRITE_BACK: begin
                rg_wr_o = 1'b0;
                pc_ld_o = 1'b0;
                case (cls_i)
                    CLS_LOAD:   wd_src_o = WD_MEM;
                    CLS_LUI:    wd_src_o = WD_IMM;
                    CLS_JAL, CLS_JALR: begin
                        wd_src_o = WD_JAL_LINK;
                        pc_src_o = PC_ALU_DIRECT;     // Jump target
                    end
                    default: ;
                endcase
            end
            ST_BUG_HALT: begin
                halt_o   = 1'b1;
                ready_o  = 1'b0;
                mem_rd_o = 1'b1;                      // Bus quiet
            end
            default: ready_o = 1'b0;
        endcase

        // Immediate format from decode through write-back
        if (state_i inside {ST_DECODE, ST_EXECUTE, ST_MEM_READ,
                            ST_MEM_WRITE, ST_WRITE_BACK}) begin
            imm_src_o = imm_sel_i;
        end
    end

endmodule

//--- rtl/cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
    input  logic                      clk_i,
    input  logic                      resetComplete,
    input  logic                      mem_busy_i,
    input  logic                      branch_taken_i,
    input  logic [ctrl_pkg::XLEN-1:0] ir_i,
    output logic                      ir_ld_o,
    output logic                      pc_ld_o,
    output logic                      mem_wr_o,
    output logic                      mem_rd_o,
    output logic                      rg_wr_o,
    output logic                      alu_ld_o,
    output logic                      jal_ld_o,
    output logic                      ready_o,
    output logic                      halt_o,
    output ctrl_pkg::pc_sel_e         pc_src_o,
    output ctrl_pkg::addr_sel_e       addr_src_o,
    output ctrl_pkg::a_sel_e          a_src_o,
    output ctrl_pkg::b_sel_e          b_src_o,
    output ctrl_pkg::imm_sel_e        imm_src_o,
    output ctrl_pkg::wd_sel_e         wd_src_o
);

    import ctrl_pkg::*;

    instr_class_e cls;          // Classifier to sequencer and matrix
    imm_sel_e     imm_sel;
    ctrl_state_e  state;        // Current step

    instr_classifier instr_classifier_inst (
        .ir_i      (ir_i),
        .cls_o     (cls),
        .imm_sel_o (imm_sel)
    );

    step_sequencer step_sequencer_inst (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .mem_busy_i    (mem_busy_i),
        .cls_i         (cls),
        .state_o       (state)
    );

    control_matrix control_matrix_inst (
        .state_i        (state),
        .cls_i          (cls),
        .imm_sel_i      (imm_sel),
        .mem_busy_i     (mem_busy_i),
        .branch_taken_i (branch_taken_i),
        .ir_ld_o        (ir_ld_o),
        .pc_ld_o        (pc_ld_o),
        .mem_wr_o       (mem_wr_o),
        .mem_rd_o       (mem_rd_o),
        .rg_wr_o        (rg_wr_o),
        .alu_ld_o       (alu_ld_o),
        .jal_ld_o       (jal_ld_o),
        .ready_o        (ready_o),
        .halt_o         (halt_o),
        .pc_src_o       (pc_src_o),
        .addr_src_o     (addr_src_o),
        .a_src_o        (a_src_o),
        .b_src_o        (b_src_o),
        .imm_src_o      (imm_src_o),
        .wd_src_o       (wd_src_o)
    );

endmodule

//--- tb/cpu_control_tb.sv
`timescale 1ns/100ps

module cpu_control_tb;

    import ctrl_pkg::*;

    typedef enum {END_WB, END_BRANCH, END_STORE, END_HALT} last_step_e;

    // DUT ports
    logic            clk_i;
    logic            resetComplete;
    logic            mem_busy_i;
    logic            branch_taken_i;
    logic [XLEN-1:0] ir_i;
    logic            ir_ld_o, pc_ld_o, mem_wr_o, mem_rd_o, rg_wr_o, alu_ld_o, jal_ld_o;
    logic            ready_o, halt_o;
    pc_sel_e         pc_src_o;
    addr_sel_e       addr_src_o;
    a_sel_e          a_src_o;
    b_sel_e          b_src_o;
    imm_sel_e        imm_src_o;
    wd_sel_e         wd_src_o;

    // Expected selects for the word now in the IR
    logic [OPC_W-1:0] opc;
    a_sel_e          exp_a;
    b_sel_e          exp_b;
    wd_sel_e         exp_wd;
    pc_sel_e         exp_pc_wb;
    imm_sel_e        exp_imm;

    string           test_name  = "reset";
    int              err_count  = 0;
    int              pass_count = 0;
    int              fail_count = 0;
    int              wait_limit = 40;           // Cycles per wait loop
    integer          seed       = 32'ha478_3a99;
    int              busy_left  = 0;
    logic            arm_req    = 1'b0;         // Next access gets a busy burst
    logic            timed_out  = 1'b0;         // Remaining tests are skipped
    logic [1:0]      rst_hist   = 2'b00;        // Reset seen on the last two edges
    logic [XLEN-1:0] legal_words [0:9];

    cpu_control cpu_control_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        rst_hist <= {rst_hist[0], resetComplete};
    end

    // ------------------------------------------------------------
    // Memory model, 0 to 3 busy cycles per access
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (arm_req) begin
            busy_left = $random(seed) & 3;
            arm_req   = 1'b0;
        end
        mem_busy_i <= (busy_left != 0);
        if (busy_left != 0) begin
            busy_left = busy_left - 1;
        end
    end

    // Operand, write-data and immediate tables per opcode
    assign opc = ir_i[OPC_W-1:0];

    always_comb begin
        exp_a     = A_RS1;
        exp_b     = B_IMM;
        exp_wd    = WD_ALU_OUT;
        exp_pc_wb = PC_ALU_OUT;
        exp_imm   = IMM_I;                      // OP, OP-IMM, LOAD, JALR
        case (opc)
            OPC_OP:    exp_b = B_RS2;
            OPC_LOAD:  exp_wd = WD_MEM;
            OPC_STORE: exp_imm = IMM_S;
            OPC_BRANCH: begin
                exp_a   = A_PC;
                exp_imm = IMM_B;
            end
            OPC_JAL: begin
                exp_a     = A_PC;
                exp_imm   = IMM_J;
                exp_wd    = WD_JAL_LINK;
                exp_pc_wb = PC_ALU_DIRECT;
            end
            OPC_JALR: begin
                exp_wd    = WD_JAL_LINK;
                exp_pc_wb = PC_ALU_DIRECT;
            end
            OPC_LUI: begin
                exp_a   = A_ZERO;
                exp_imm = IMM_U;
                exp_wd  = WD_IMM;
            end
            OPC_AUIPC: begin
                exp_a   = A_PC;
                exp_imm = IMM_U;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // Reset, fetch and halt checks
    // ------------------------------------------------------------
    reset_hold_a: assert property (@(posedge clk_i)
        resetComplete && rst_hist[0] |-> !pc_ld_o && !ready_o && pc_src_o == PC_RESET_VECTOR)
        else flag_mismatch("{pc_ld,ready,pc_src} in reset", {2'b00, PC_RESET_VECTOR},
                           $sampled({pc_ld_o, ready_o, pc_src_o}));
    vector2_a: assert property (@(posedge clk_i)
        !resetComplete && rst_hist == 2'b10 |-> ready_o && ir_ld_o)
        else flag_mismatch("{ready,ir_ld} after release", 3, $sampled({ready_o, ir_ld_o}));
    ready_hold_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        rst_hist == 2'b00 && !halt_o |-> ready_o)
        else flag_mismatch("ready_o", 1, $sampled(ready_o));
    load_busy_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        mem_busy_i |-> ir_ld_o)
        else note_error("ir_ld_o low while memory is busy");
    load_pulse_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !ir_ld_o |=> ir_ld_o)
        else note_error("ir_ld_o low for more than one cycle");
    halt_quiet_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        halt_o |-> !ready_o && (&{ir_ld_o, pc_ld_o, mem_wr_o, mem_rd_o, rg_wr_o,
                                  alu_ld_o, jal_ld_o}))
        else flag_mismatch("{ready,strobes} in halt", 8'h7F,
                           $sampled({ready_o, ir_ld_o, pc_ld_o, mem_wr_o, mem_rd_o,
                                     rg_wr_o, alu_ld_o, jal_ld_o}));
    halt_sticky_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        halt_o |=> halt_o)
        else note_error("halt_o dropped without a reset");

    // ------------------------------------------------------------
    // Execute and write-back selects
    // ------------------------------------------------------------
    a_src_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !alu_ld_o |-> a_src_o == exp_a)
        else flag_mismatch("a_src_o", $sampled(exp_a), $sampled(a_src_o));
    b_src_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !alu_ld_o |-> b_src_o == exp_b)
        else flag_mismatch("b_src_o", $sampled(exp_b), $sampled(b_src_o));
    branch_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !alu_ld_o |-> pc_ld_o == !(opc == OPC_BRANCH && branch_taken_i))
        else flag_mismatch("pc_ld_o in execute",
                           !($sampled(opc) == OPC_BRANCH && $sampled(branch_taken_i)),
                           $sampled(pc_ld_o));
    link_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !alu_ld_o |-> jal_ld_o == !(opc == OPC_JAL || opc == OPC_JALR))
        else note_error("jal_ld_o does not match the jump class in execute");
    wd_src_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !rg_wr_o |-> wd_src_o == exp_wd)
        else flag_mismatch("wd_src_o", $sampled(exp_wd), $sampled(wd_src_o));
    pc_src_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !rg_wr_o |-> !pc_ld_o && pc_src_o == exp_pc_wb)
        else flag_mismatch("{pc_ld,pc_src} in write-back", $sampled(exp_pc_wb),
                           $sampled({pc_ld_o, pc_src_o}));
    imm_src_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !alu_ld_o || !rg_wr_o |-> imm_src_o == exp_imm)
        else flag_mismatch("imm_src_o", $sampled(exp_imm), $sampled(imm_src_o));
    store_a: assert property (@(posedge clk_i) disable iff (resetComplete)
        !mem_wr_o |-> opc == OPC_STORE && addr_src_o == ADDR_ALU_OUT)
        else note_error("mem_wr_o low outside a store's memory step");

    task automatic flag_mismatch(input string sig, input int expected, input int actual);
        err_count++;
        $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, sig, expected, actual);
    endtask

    task automatic note_error(input string what);
        err_count++;
        $display("ERROR %s: %s", test_name, what);
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        fail_count++;
        $display("TIMEOUT %s: %s within %0d cycles", test_name, what, wait_limit);
    endtask

    task automatic close_test(input int errs_before);
        @(negedge clk_i);                       // Let the last edge's checks land
        if (err_count == errs_before) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s", test_name);
        end
    endtask

    function automatic last_step_e last_step_of(input logic [OPC_W-1:0] op);
        case (op)
            OPC_BRANCH: return END_BRANCH;
            OPC_STORE:  return END_STORE;
            OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC:
                return END_WB;
            default:    return END_HALT;
        endcase
    endfunction

    // Ends on a falling edge
    task automatic apply_reset(input string name);
        int errs_before;
        if (timed_out) return;
        test_name     = name;
        errs_before   = err_count;
        resetComplete = 1'b1;
        repeat (10) @(posedge clk_i);           // Ten reset cycles
        @(negedge clk_i);
        resetComplete = 1'b0;
        repeat (2) @(posedge clk_i);            // Vector steps 1 and 2
        arm_req = 1'b1;                         // Fetch comes next
        close_test(errs_before);
    endtask

    task automatic execute_instr(input string name, input logic [XLEN-1:0] word,
                                 input logic taken);
        int         n;
        int         rg_pulses;
        int         wr_cycles;
        int         extra_loads;
        int         errs_before;
        logic       done;
        last_step_e kind;
        if (timed_out) return;
        test_name   = name;
        errs_before = err_count;
        kind        = last_step_of(word[OPC_W-1:0]);
        rg_pulses   = 0;
        wr_cycles   = 0;
        extra_loads = 0;
        done        = 1'b0;
        n           = 0;
        do begin
            @(posedge clk_i);
            n++;
            rg_pulses += !rg_wr_o;              // No register write during fetch
        end while (ir_ld_o !== 1'b0 && n < wait_limit);
        if (ir_ld_o !== 1'b0) begin
            report_timeout("IR was never loaded in fetch");
            return;
        end
        @(negedge clk_i);
        ir_i           = word;                  // IR register output after the load
        branch_taken_i = taken;
        n              = 0;
        while (!done && n < wait_limit) begin
            @(posedge clk_i);
            n++;
            rg_pulses   += !rg_wr_o;
            wr_cycles   += !mem_wr_o;
            extra_loads += !ir_ld_o;
            if (!alu_ld_o && (opc == OPC_LOAD || opc == OPC_STORE)) begin
                arm_req = 1'b1;                 // Data access follows execute
            end
            case (kind)
                END_WB:     done = !rg_wr_o;
                END_BRANCH: done = !alu_ld_o;
                END_STORE:  done = !mem_wr_o && !mem_busy_i;
                default:    done = halt_o;
            endcase
        end
        if (!done) begin
            report_timeout("instruction did not reach its last step");
            return;
        end
        assert (rg_pulses == (kind == END_WB ? 1 : 0))
            else flag_mismatch("rg_wr_o pulses", (kind == END_WB ? 1 : 0), rg_pulses);
        assert ((wr_cycles > 0) == (kind == END_STORE))
            else note_error($sformatf("mem_wr_o low for %0d cycles", wr_cycles));
        assert (extra_loads == 0)
            else flag_mismatch("extra ir_ld_o pulses", 0, extra_loads);
        if (kind == END_HALT) begin
            repeat (4) @(posedge clk_i);        // Halt must hold
        end else begin
            arm_req = 1'b1;
        end
        close_test(errs_before);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        int   r;
        int   picks [0:11];
        logic taken_flags [0:11];
        resetComplete  = 1'b1;
        mem_busy_i     = 1'b0;
        branch_taken_i = 1'b0;
        ir_i           = 32'h0000_0013;         // addi x0, x0, 0
        legal_words[0] = 32'h0020_81B3;         // add   x3, x1, x2
        legal_words[1] = 32'h0050_8093;         // addi  x1, x1, 5
        legal_words[2] = 32'h0040_A103;         // lw    x2, 4(x1)
        legal_words[3] = 32'h0020_A423;         // sw    x2, 8(x1)
        legal_words[4] = 32'h0020_8463;         // beq   x1, x2, +8
        legal_words[5] = 32'h0080_00EF;         // jal   x1, +8
        legal_words[6] = 32'h0000_80E7;         // jalr  x1, 0(x1)
        legal_words[7] = 32'h1234_50B7;         // lui   x1, 0x12345
        legal_words[8] = 32'h0000_1097;         // auipc x1, 0x1
        legal_words[9] = 32'h0020_E1B3;         // or    x3, x1, x2

        // Random mix drawn up front
        for (int i = 0; i < 12; i++) begin
            r              = $random(seed);
            picks[i]       = (r & 32'h7FFF_FFFF) % 10;
            taken_flags[i] = r[16];
        end

        apply_reset("reset_vector");
        execute_instr("add", legal_words[0], 1'b0);
        execute_instr("addi", legal_words[1], 1'b0);
        execute_instr("lw", legal_words[2], 1'b0);
        execute_instr("sw", legal_words[3], 1'b0);
        execute_instr("beq_taken", legal_words[4], 1'b1);
        execute_instr("beq_not_taken", legal_words[4], 1'b0);
        execute_instr("jal", legal_words[5], 1'b0);
        execute_instr("jalr", legal_words[6], 1'b0);
        execute_instr("lui", legal_words[7], 1'b0);
        execute_instr("auipc", legal_words[8], 1'b0);
        for (int i = 0; i < 12; i++) begin
            execute_instr($sformatf("random_%0d", i), legal_words[picks[i]], taken_flags[i]);
        end
        execute_instr("illegal_fence", 32'h0000_000F, 1'b0);
        apply_reset("reset_after_halt");
        execute_instr("add_after_halt", legal_words[0], 1'b0);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/ctrl_pkg.sv
rtl/instr_classifier.sv
rtl/step_sequencer.sv
rtl/control_matrix.sv
rtl/cpu_control.sv
tb/cpu_control_tb.sv

//--- Bender.yml
package:
  name: cpu_control

sources:
  - rtl/ctrl_pkg.sv
  - rtl/instr_classifier.sv
  - rtl/step_sequencer.sv
  - rtl/control_matrix.sv
  - rtl/cpu_control.sv
  - target: test
    files:
      - tb/cpu_control_tb.sv
